// ==== Bender.yml ====
package:
  name: rv32i_exec_slice

sources:
  - files:
      - source/rv32i_pkg.sv
      - source/ctrl_if.sv
      - source/instr_fifo.sv
      - source/control_memory.sv
      - source/regfile.sv
      - source/execute_unit.sv
      - source/rv32i_exec_slice.sv
  - target: test
    files:
      - verif/rv32i_exec_slice_chk.sv
      - verif/rv32i_exec_slice_tb.sv

// ==== build.f ====
source/rv32i_pkg.sv
source/ctrl_if.sv
source/instr_fifo.sv
source/control_memory.sv
source/regfile.sv
source/execute_unit.sv
source/rv32i_exec_slice.sv
verif/rv32i_exec_slice_chk.sv
verif/rv32i_exec_slice_tb.sv

// ==== source/control_memory.sv ====
`timescale 1ns/1ps

module control_memory (
    input  rv32i_pkg::rv32i_word instr,
    ctrl_if.dec                  ctrl
);

    rv32i_pkg::rv32i_word i_imm;
    rv32i_pkg::rv32i_word s_imm;
    rv32i_pkg::rv32i_word b_imm;
    rv32i_pkg::rv32i_word u_imm;
    rv32i_pkg::rv32i_word j_imm;
    logic [2:0]           funct3;
    logic                 bit30;

    // ========================================
    // Fields and immediates
    // ========================================
    assign i_imm  = {{21{instr[31]}}, instr[30:20]};
    assign s_imm  = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign b_imm  = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm  = {instr[31:12], 12'h000};
    assign j_imm  = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign funct3 = instr[14:12];
    assign bit30  = instr[30];

    assign ctrl.opcode = rv32i_pkg::rv32i_opcode'(instr[6:0]);
    assign ctrl.rs1    = instr[19:15];
    assign ctrl.rs2    = instr[24:20];
    assign ctrl.rd     = instr[11:7];

    // ========================================
    // Control word
    // ========================================
    always_comb begin
        ctrl.aluop          = rv32i_pkg::alu_ops'(funct3);
        ctrl.alt            = 1'b0;
        ctrl.cmpop          = rv32i_pkg::beq;
        ctrl.alumux1_sel    = rv32i_pkg::alumux1_rs1;
        ctrl.alumux2_sel    = rv32i_pkg::alumux2_imm;
        ctrl.regfilemux_sel = rv32i_pkg::rfmux_alu;
        ctrl.cmpmux_sel     = rv32i_pkg::cmpmux_rs2;
        ctrl.load_regfile   = 1'b0;
        ctrl.jb_sel         = rv32i_pkg::jb_none;
        ctrl.imm            = i_imm;
        ctrl.illegal        = 1'b0;

        case (ctrl.opcode)
            rv32i_pkg::op_lui: begin
                ctrl.load_regfile   = 1'b1;
                ctrl.regfilemux_sel = rv32i_pkg::rfmux_imm;
                ctrl.imm            = u_imm;
            end
            rv32i_pkg::op_auipc: begin
                ctrl.load_regfile = 1'b1;
                ctrl.alumux1_sel  = rv32i_pkg::alumux1_pc;
                ctrl.aluop        = rv32i_pkg::alu_add;
                ctrl.imm          = u_imm;
            end
            rv32i_pkg::op_jal: begin
                ctrl.load_regfile   = 1'b1;
                ctrl.regfilemux_sel = rv32i_pkg::rfmux_pc4;
                ctrl.alumux1_sel    = rv32i_pkg::alumux1_pc;  // ALU forms the target.
                ctrl.aluop          = rv32i_pkg::alu_add;
                ctrl.jb_sel         = rv32i_pkg::jb_jal;
                ctrl.imm            = j_imm;
            end
            rv32i_pkg::op_jalr: begin
                ctrl.load_regfile   = 1'b1;
                ctrl.regfilemux_sel = rv32i_pkg::rfmux_pc4;
                ctrl.aluop          = rv32i_pkg::alu_add;
                ctrl.jb_sel         = rv32i_pkg::jb_jalr;
            end
            rv32i_pkg::op_br: begin
                ctrl.alumux1_sel = rv32i_pkg::alumux1_pc;
                ctrl.aluop       = rv32i_pkg::alu_add;
                ctrl.cmpop       = rv32i_pkg::branch_funct3_t'(funct3);
                ctrl.jb_sel      = rv32i_pkg::jb_branch;
                ctrl.imm         = b_imm;
                if (funct3[2:1] == 2'b01) begin     // No branch on 010 and 011.
                    ctrl.jb_sel  = rv32i_pkg::jb_none;
                    ctrl.illegal = 1'b1;
                end
            end
            rv32i_pkg::op_imm, rv32i_pkg::op_reg: begin
                ctrl.load_regfile = 1'b1;
                if (ctrl.opcode == rv32i_pkg::op_reg) begin
                    ctrl.alumux2_sel = rv32i_pkg::alumux2_rs2;
                    ctrl.alt         = bit30 && (funct3 == 3'b000 || funct3 == 3'b101);
                end else begin
                    ctrl.cmpmux_sel = rv32i_pkg::cmpmux_imm;
                    ctrl.alt        = bit30 && (funct3 == 3'b101);
                end
                if (funct3 == 3'b010) begin
                    ctrl.cmpop          = rv32i_pkg::blt;
                    ctrl.regfilemux_sel = rv32i_pkg::rfmux_cmp;
                end else if (funct3 == 3'b011) begin
                    ctrl.cmpop          = rv32i_pkg::bltu;
                    ctrl.regfilemux_sel = rv32i_pkg::rfmux_cmp;
                end
            end
            rv32i_pkg::op_load, rv32i_pkg::op_store: begin
                ctrl.illegal = 1'b1;                // No data memory in this slice.
                ctrl.imm     = (ctrl.opcode == rv32i_pkg::op_store) ? s_imm : i_imm;
            end
            default: begin
                ctrl.illegal = 1'b1;
            end
        endcase
    end

endmodule

// ==== source/ctrl_if.sv ====
`timescale 1ns/1ps

interface ctrl_if;
    rv32i_pkg::rv32i_opcode     opcode;
    rv32i_pkg::alu_ops          aluop;
    logic                       alt;              // Selects sub or sra.
    rv32i_pkg::branch_funct3_t  cmpop;
    rv32i_pkg::alumux1_sel_t    alumux1_sel;
    rv32i_pkg::alumux2_sel_t    alumux2_sel;
    rv32i_pkg::regfilemux_sel_t regfilemux_sel;
    rv32i_pkg::cmpmux_sel_t     cmpmux_sel;
    logic                       load_regfile;
    rv32i_pkg::jb_sel_t         jb_sel;
    rv32i_pkg::rv32i_word       imm;
    rv32i_pkg::rv32i_reg        rs1;
    rv32i_pkg::rv32i_reg        rs2;
    rv32i_pkg::rv32i_reg        rd;
    logic                       illegal;

    modport dec (output opcode, aluop, alt, cmpop, alumux1_sel, alumux2_sel, regfilemux_sel,
                 cmpmux_sel, load_regfile, jb_sel, imm, rs1, rs2, rd, illegal);

    modport exe (input opcode, aluop, alt, cmpop, alumux1_sel, alumux2_sel, regfilemux_sel,
                 cmpmux_sel, load_regfile, jb_sel, imm, rd, illegal);
endinterface

// ==== source/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit (
    input  logic                 clk,
    input  logic                 arst_n,
    ctrl_if.exe                  ctrl,
    input  rv32i_pkg::rv32i_word rs1_data,
    input  rv32i_pkg::rv32i_word rs2_data,
    input  rv32i_pkg::rv32i_word pc,
    input  logic                 avail,
    input  logic                 out_credit,
    output logic                 pop,
    output logic                 rf_we,
    output rv32i_pkg::rv32i_reg  rf_waddr,
    output rv32i_pkg::rv32i_word rf_wdata,
    output logic                 out_valid,
    output rv32i_pkg::rv32i_reg  out_rd,
    output rv32i_pkg::rv32i_word out_data,
    output logic                 out_we,
    output logic                 out_redirect,
    output rv32i_pkg::rv32i_word out_target,
    output logic                 out_illegal
);

    rv32i_pkg::out_credit_cnt_t credits;
    rv32i_pkg::rv32i_word       alu_a, alu_b, alu_out, cmp_b, wb_data, target;
    rv32i_pkg::alu_ops          op;
    logic                       cmp_out;
    logic                       redirect;

    // ========================================
    // ALU and comparator
    // ========================================
    assign alu_a = (ctrl.alumux1_sel == rv32i_pkg::alumux1_pc) ? pc : rs1_data;
    assign alu_b = (ctrl.alumux2_sel == rv32i_pkg::alumux2_rs2) ? rs2_data : ctrl.imm;
    assign cmp_b = (ctrl.cmpmux_sel == rv32i_pkg::cmpmux_imm) ? ctrl.imm : rs2_data;

    always_comb begin
        op = ctrl.aluop;
        if (ctrl.alt && ctrl.aluop == rv32i_pkg::alu_add) begin
            op = rv32i_pkg::alu_sub;
        end else if (ctrl.alt && ctrl.aluop == rv32i_pkg::alu_srl) begin
            op = rv32i_pkg::alu_sra;
        end
        case (op)
            rv32i_pkg::alu_add: alu_out = alu_a + alu_b;
            rv32i_pkg::alu_sub: alu_out = alu_a - alu_b;
            rv32i_pkg::alu_sll: alu_out = alu_a << alu_b[4:0];
            rv32i_pkg::alu_srl: alu_out = alu_a >> alu_b[4:0];
            rv32i_pkg::alu_sra: alu_out = $unsigned($signed(alu_a) >>> alu_b[4:0]);
            rv32i_pkg::alu_xor: alu_out = alu_a ^ alu_b;
            rv32i_pkg::alu_or:  alu_out = alu_a | alu_b;
            default:            alu_out = alu_a & alu_b;
        endcase
    end

    always_comb begin
        case (ctrl.cmpop)
            rv32i_pkg::beq:  cmp_out = (rs1_data == cmp_b);
            rv32i_pkg::bne:  cmp_out = (rs1_data != cmp_b);
            rv32i_pkg::blt:  cmp_out = ($signed(rs1_data) < $signed(cmp_b));
            rv32i_pkg::bge:  cmp_out = ($signed(rs1_data) >= $signed(cmp_b));
            rv32i_pkg::bltu: cmp_out = (rs1_data < cmp_b);
            rv32i_pkg::bgeu: cmp_out = (rs1_data >= cmp_b);
            default:         cmp_out = 1'b0;
        endcase
    end

    // ========================================
    // Write-back and control flow
    // ========================================
    always_comb begin
        case (ctrl.regfilemux_sel)
            rv32i_pkg::rfmux_cmp: wb_data = {31'b0, cmp_out};
            rv32i_pkg::rfmux_imm: wb_data = ctrl.imm;
            rv32i_pkg::rfmux_pc4: wb_data = pc + 32'd4;
            default:              wb_data = alu_out;
        endcase
        case (ctrl.jb_sel)
            rv32i_pkg::jb_branch:             redirect = cmp_out;
            rv32i_pkg::jb_jal, rv32i_pkg::jb_jalr: redirect = 1'b1;
            default:                          redirect = 1'b0;
        endcase
    end

    // jalr drops bit 0, branch and jal use the ALU sum as is.
    assign target   = (ctrl.jb_sel == rv32i_pkg::jb_jalr) ? {alu_out[31:1], 1'b0} : alu_out;

    assign pop      = avail && (credits != '0);
    assign rf_we    = pop && ctrl.load_regfile;
    assign rf_waddr = ctrl.rd;
    assign rf_wdata = wb_data;

    // ========================================
    // Result record and downstream credits
    // ========================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            credits   <= rv32i_pkg::OUT_CREDITS_RST;
        end else begin
            out_valid <= pop;
            case ({pop, out_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            out_rd       <= ctrl.rd;
            out_data     <= ctrl.load_regfile ? wb_data : '0;  // Zero when nothing is written.
            out_we       <= ctrl.load_regfile;
            out_redirect <= redirect;
            out_target   <= target;
            out_illegal  <= ctrl.illegal;
        end
    end

endmodule

// ==== source/instr_fifo.sv ====
`timescale 1ns/1ps

module instr_fifo (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 push,
    input  rv32i_pkg::rv32i_word push_instr,
    input  rv32i_pkg::rv32i_word push_pc,
    input  logic                 pop,
    output rv32i_pkg::rv32i_word head_instr,
    output rv32i_pkg::rv32i_word head_pc,
    output logic                 empty,
    output logic                 credit
);

    rv32i_pkg::rv32i_word instr_mem [rv32i_pkg::IN_CREDITS];
    rv32i_pkg::rv32i_word pc_mem    [rv32i_pkg::IN_CREDITS];

    rv32i_pkg::fifo_ptr_t wr_ptr;
    rv32i_pkg::fifo_ptr_t rd_ptr;
    rv32i_pkg::fifo_cnt_t count;

    always_ff @(posedge clk) begin
        if (push) begin
            instr_mem[wr_ptr] <= push_instr;
            pc_mem[wr_ptr]    <= push_pc;
        end
    end

    // Pointers wrap on their own, depth is a power of two.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            credit <= pop;                          // One credit back per pop.
        end
    end

    assign head_instr = instr_mem[rd_ptr];
    assign head_pc    = pc_mem[rd_ptr];
    assign empty      = (count == '0);

endmodule

// ==== source/regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 we,
    input  rv32i_pkg::rv32i_reg  waddr,
    input  rv32i_pkg::rv32i_word wdata,
    input  rv32i_pkg::rv32i_reg  raddr1,
    input  rv32i_pkg::rv32i_reg  raddr2,
    output rv32i_pkg::rv32i_word rdata1,
    output rv32i_pkg::rv32i_word rdata2
);

    rv32i_pkg::rv32i_word regs [32];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin   // x0 stays zero.
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

// ==== source/rv32i_exec_slice.sv ====
`timescale 1ns/1ps

module rv32i_exec_slice (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 in_valid,
    input  rv32i_pkg::rv32i_word in_instr,
    input  rv32i_pkg::rv32i_word in_pc,
    output logic                 in_credit,
    input  logic                 out_credit,
    output logic                 out_valid,
    output rv32i_pkg::rv32i_reg  out_rd,
    output rv32i_pkg::rv32i_word out_data,
    output logic                 out_we,
    output logic                 out_redirect,
    output rv32i_pkg::rv32i_word out_target,
    output logic                 out_illegal
);

    rv32i_pkg::rv32i_word head_instr, head_pc;
    rv32i_pkg::rv32i_word rs1_data, rs2_data, rf_wdata;
    rv32i_pkg::rv32i_reg  rf_waddr;
    logic                 empty, pop, rf_we;

    ctrl_if ctrl_bus ();

    instr_fifo instr_fifo_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .push       (in_valid),
        .push_instr (in_instr),
        .push_pc    (in_pc),
        .pop        (pop),
        .head_instr (head_instr),
        .head_pc    (head_pc),
        .empty      (empty),
        .credit     (in_credit)
    );

    control_memory control_memory_i (
        .instr (head_instr),
        .ctrl  (ctrl_bus.dec)
    );

    // Register indices come straight off the decoded head.
    regfile regfile_i (
        .clk    (clk),
        .arst_n (arst_n),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .raddr1 (ctrl_bus.rs1),
        .raddr2 (ctrl_bus.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    execute_unit execute_unit_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .ctrl         (ctrl_bus.exe),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .pc           (head_pc),
        .avail        (!empty),
        .out_credit   (out_credit),
        .pop          (pop),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .out_valid    (out_valid),
        .out_rd       (out_rd),
        .out_data     (out_data),
        .out_we       (out_we),
        .out_redirect (out_redirect),
        .out_target   (out_target),
        .out_illegal  (out_illegal)
    );

endmodule

// ==== source/rv32i_pkg.sv ====
package rv32i_pkg;

    // ========================================
    // Widths and credit constants
    // ========================================
    typedef logic [31:0] rv32i_word;
    typedef logic [4:0]  rv32i_reg;

    localparam int IN_CREDITS  = 4;                 // FIFO depth and upstream credits.
    localparam int OUT_CREDITS = 2;                 // Downstream credits at reset.

    typedef logic [$clog2(IN_CREDITS)-1:0]    fifo_ptr_t;
    typedef logic [$clog2(IN_CREDITS+1)-1:0]  fifo_cnt_t;
    typedef logic [$clog2(OUT_CREDITS+1)-1:0] out_credit_cnt_t;

    localparam out_credit_cnt_t OUT_CREDITS_RST = out_credit_cnt_t'(OUT_CREDITS);

    // ========================================
    // Encodings
    // ========================================
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    // Follows funct3, sub and sra sit on the slt and sltu codes.
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_ops;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    typedef enum logic {alumux1_rs1, alumux1_pc} alumux1_sel_t;
    typedef enum logic {alumux2_imm, alumux2_rs2} alumux2_sel_t;
    typedef enum logic {cmpmux_rs2, cmpmux_imm} cmpmux_sel_t;

    typedef enum logic [1:0] {rfmux_alu, rfmux_cmp, rfmux_imm, rfmux_pc4} regfilemux_sel_t;
    typedef enum logic [1:0] {jb_none, jb_branch, jb_jal, jb_jalr} jb_sel_t;

endpackage

// ==== verif/rv32i_exec_slice_chk.sv ====
`timescale 1ns/1ps

module rv32i_exec_slice_chk (
    input logic                 clk,
    input logic                 arst_n,
    input logic                 in_valid,
    input logic                 in_credit,
    input logic                 out_valid,
    input logic                 out_credit,
    input rv32i_pkg::fifo_cnt_t fifo_count
);

    int granted;                                    // Receiver's view of credits still open.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            granted <= rv32i_pkg::OUT_CREDITS;
        end else begin
            granted <= granted - int'(out_valid) + int'(out_credit);
        end
    end

    // A result leaves only on a credit the receiver granted.
    out_needs_credit: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> granted > 0)
        else $error("out_valid without a downstream credit");

    no_push_when_full: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid |-> fifo_count < rv32i_pkg::IN_CREDITS)
        else $error("push into a full instruction FIFO");

    quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !out_valid && !in_credit)
        else $error("out_valid or in_credit high during reset");

endmodule

bind rv32i_exec_slice rv32i_exec_slice_chk rv32i_exec_slice_chk_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_credit (out_credit),
    .fifo_count (instr_fifo_i.count)
);

// ==== verif/rv32i_exec_slice_tb.sv ====
`timescale 1ns/1ps

module rv32i_exec_slice_tb;

    localparam int NUM_INSTR   = 300;
    localparam int TIMEOUT_CYC = 20 * NUM_INSTR + 200;

    typedef struct {
        string                name;
        rv32i_pkg::rv32i_reg  rd;
        rv32i_pkg::rv32i_word data;
        logic                 we;
        logic                 redirect;
        rv32i_pkg::rv32i_word target;
        logic                 illegal;
    } result_t;

    logic                 clk;
    logic                 arst_n;
    logic                 in_valid;
    rv32i_pkg::rv32i_word in_instr;
    rv32i_pkg::rv32i_word in_pc;
    logic                 in_credit;
    logic                 out_credit;
    logic                 out_valid;
    rv32i_pkg::rv32i_reg  out_rd;
    rv32i_pkg::rv32i_word out_data;
    logic                 out_we;
    logic                 out_redirect;
    rv32i_pkg::rv32i_word out_target;
    logic                 out_illegal;

    rv32i_pkg::rv32i_word model_regs [32];
    result_t              exp_q [$];
    int                   cycles;
    int                   sent;
    int                   received;
    int                   credit_returns;
    int                   pending_credits;
    int                   first_send_cycle;

    rv32i_exec_slice rv32i_exec_slice_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .in_instr     (in_instr),
        .in_pc        (in_pc),
        .in_credit    (in_credit),
        .out_credit   (out_credit),
        .out_valid    (out_valid),
        .out_rd       (out_rd),
        .out_data     (out_data),
        .out_we       (out_we),
        .out_redirect (out_redirect),
        .out_target   (out_target),
        .out_illegal  (out_illegal)
    );

    always #4 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input rv32i_pkg::rv32i_word expected,
                         input rv32i_pkg::rv32i_word actual);
        if (expected !== actual) begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            abort_run("stopping at the first mismatch");
        end
    endtask

    // ========================================
    // Reference model
    // ========================================
    function automatic rv32i_pkg::rv32i_word alu_ref(input logic [2:0] f3, input logic alt,
                                                     input rv32i_pkg::rv32i_word x,
                                                     input rv32i_pkg::rv32i_word y);
        case (f3)
            3'd0:    return alt ? x - y : x + y;
            3'd1:    return x << y[4:0];
            3'd2:    return {31'b0, $signed(x) < $signed(y)};
            3'd3:    return {31'b0, x < y};
            3'd4:    return x ^ y;
            3'd5:    return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
            3'd6:    return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic logic taken_ref(input logic [2:0] f3, input rv32i_pkg::rv32i_word x,
                                       input rv32i_pkg::rv32i_word y);
        case (f3)
            3'd0:    return x == y;
            3'd1:    return x != y;
            3'd4:    return $signed(x) < $signed(y);
            3'd5:    return $signed(x) >= $signed(y);
            3'd6:    return x < y;
            default: return x >= y;
        endcase
    endfunction

    function automatic result_t predict(input rv32i_pkg::rv32i_word instr,
                                        input rv32i_pkg::rv32i_word pc, input int idx);
        result_t              r;
        string                kind;
        rv32i_pkg::rv32i_word a;
        rv32i_pkg::rv32i_word b;
        rv32i_pkg::rv32i_word i_imm;
        rv32i_pkg::rv32i_word u_imm;
        rv32i_pkg::rv32i_word j_imm;
        rv32i_pkg::rv32i_word b_imm;
        logic [2:0]           f3;
        a        = model_regs[instr[19:15]];
        b        = model_regs[instr[24:20]];
        f3       = instr[14:12];
        i_imm    = {{20{instr[31]}}, instr[31:20]};
        u_imm    = {instr[31:12], 12'h000};
        j_imm    = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        b_imm    = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        r.rd       = instr[11:7];
        r.data     = '0;
        r.we       = 1'b0;
        r.redirect = 1'b0;
        r.target   = '0;
        r.illegal  = 1'b0;
        kind       = "illegal";
        case (instr[6:0])
            7'b0110011: begin
                kind   = "op";
                r.we   = 1'b1;
                r.data = alu_ref(f3, instr[30], a, b);
            end
            7'b0010011: begin
                kind   = "op-imm";
                r.we   = 1'b1;
                r.data = alu_ref(f3, instr[30] && f3 == 3'd5, a, i_imm);   // No subi.
            end
            7'b0110111: begin
                kind   = "lui";
                r.we   = 1'b1;
                r.data = u_imm;
            end
            7'b0010111: begin
                kind   = "auipc";
                r.we   = 1'b1;
                r.data = pc + u_imm;
            end
            7'b1101111: begin
                kind       = "jal";
                r.we       = 1'b1;
                r.data     = pc + 32'd4;
                r.redirect = 1'b1;
                r.target   = pc + j_imm;
            end
            7'b1100111: begin
                kind       = "jalr";
                r.we       = 1'b1;
                r.data     = pc + 32'd4;
                r.redirect = 1'b1;
                r.target   = (a + i_imm) & ~32'd1;   // Uses rs1 before the write.
            end
            7'b1100011: begin
                kind       = "branch";
                r.redirect = taken_ref(f3, a, b);
                r.target   = pc + b_imm;
            end
            default: begin
                r.illegal = 1'b1;
            end
        endcase
        if (r.we && r.rd != 5'd0) begin
            model_regs[r.rd] = r.data;
        end
        r.name = $sformatf("instr %0d %s", idx, kind);
        return r;
    endfunction

    // Registers x0 to x3 only, so results feed each other often.
    function automatic rv32i_pkg::rv32i_word gen_instr();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm12;
        logic [6:0]  bad_op;
        rd    = 5'($urandom % 4);
        rs1   = 5'($urandom % 4);
        rs2   = 5'($urandom % 4);
        f3    = 3'($urandom);
        imm12 = 12'($urandom);
        f7    = ((f3 == 3'd0 || f3 == 3'd5) && $urandom % 2 == 1) ? 7'h20 : 7'h00;
        case ($urandom % 10)
            0, 1, 2: return {f7, rs2, rs1, f3, rd, 7'b0110011};
            3, 4: begin
                if (f3 == 3'd1) begin
                    imm12 = {7'h00, imm12[4:0]};
                end else if (f3 == 3'd5) begin
                    imm12 = {f7, imm12[4:0]};
                end
                return {imm12, rs1, f3, rd, 7'b0010011};
            end
            5: return {20'($urandom), rd, ($urandom % 2 == 1) ? 7'b0110111 : 7'b0010111};
            6: begin
                if ($urandom % 2 == 1) begin
                    return {20'($urandom), rd, 7'b1101111};
                end
                return {imm12, rs1, 3'b000, rd, 7'b1100111};
            end
            7, 8: begin
                if (f3[2:1] == 2'b01) begin
                    f3 = f3 ^ 3'b100;                // Fold onto bltu and bgeu.
                end
                return {7'($urandom), rs2, rs1, f3, 5'($urandom), 7'b1100011};
            end
            default: begin
                case ($urandom % 4)
                    0:       bad_op = 7'b0000011;   // Load.
                    1:       bad_op = 7'b0100011;   // Store.
                    2:       bad_op = 7'b0001111;   // Fence.
                    default: bad_op = 7'b1110011;   // System.
                endcase
                return {25'($urandom), bad_op};
            end
        endcase
    endfunction

    // ========================================
    // Stimulus
    // ========================================
    initial begin
        rv32i_pkg::rv32i_word instr;
        rv32i_pkg::rv32i_word pc;
        void'($urandom(47574));
        clk              = 1'b0;
        arst_n           = 1'b0;
        in_valid         = 1'b0;
        in_instr         = '0;
        in_pc            = '0;
        out_credit       = 1'b0;
        cycles           = 0;
        sent             = 0;
        received         = 0;
        credit_returns   = 0;
        pending_credits  = 0;
        first_send_cycle = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        repeat (4) begin
            @(posedge clk);
            check("idle out_valid", 0, out_valid);
            check("idle in_credit", 0, in_credit);
        end
        while (sent < NUM_INSTR) begin
            @(posedge clk);
            if (rv32i_pkg::IN_CREDITS - sent + credit_returns > 0 && $urandom % 4 != 0) begin
                instr = gen_instr();
                pc    = $urandom & 32'hffff_fffc;
                exp_q.push_back(predict(instr, pc, sent));
                if (sent == 0) begin
                    first_send_cycle = cycles;
                end
                in_valid <= 1'b1;
                in_instr <= instr;
                in_pc    <= pc;
                sent++;
            end else begin
                in_valid <= 1'b0;
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
        while (received < NUM_INSTR || pending_credits != 0) begin
            @(posedge clk);
        end
        check("in_credit pulses", NUM_INSTR, credit_returns);
        $display("ALL CHECKS PASSED");
        $finish;
    end

    // Downstream side, credits come back after random delays.
    always @(posedge clk) begin
        if (pending_credits > 0 && $urandom % 3 == 0) begin
            out_credit      <= 1'b1;
            pending_credits <= pending_credits - 1 + int'(out_valid);
        end else begin
            out_credit      <= 1'b0;
            pending_credits <= pending_credits + int'(out_valid);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (in_credit) begin
            credit_returns <= credit_returns + 1;
        end
        if (cycles >= TIMEOUT_CYC) begin
            abort_run("the run timed out before all results and credits came back");
        end
    end

    // ========================================
    // Comparison
    // ========================================
    always @(posedge clk) begin : compare_results
        result_t e;
        if (out_valid) begin
            if (exp_q.size() == 0) begin
                abort_run("a result arrived with no instruction outstanding");
            end else begin
                e = exp_q.pop_front();
                if (received == 0) begin
                    // Drive edge to sample edge, two cycles of in_valid to out_valid.
                    check("first result latency", 3, cycles - first_send_cycle);
                end
                check({e.name, " rd"}, e.rd, out_rd);
                check({e.name, " we"}, e.we, out_we);
                check({e.name, " data"}, e.data, out_data);
                check({e.name, " illegal"}, e.illegal, out_illegal);
                check({e.name, " redirect"}, e.redirect, out_redirect);
                if (e.redirect) begin
                    check({e.name, " target"}, e.target, out_target);
                end
                received <= received + 1;
            end
        end
    end

endmodule
